/* testbench/bridge_stimulus.dat */
# op(1=write) id addr size strb wdata slave_err xfers resp rdata
# all fields hex, one AXI command per line
1 1 00000100 3 ff 1122334455667788 0 1 0 0000000000000000
0 2 00000100 3 00 0000000000000000 0 1 0 1122334455667788
1 3 00000100 3 0f aaaaaaaabbbbbbbb 0 1 0 0000000000000000
0 4 00000100 3 00 0000000000000000 0 1 0 11223344bbbbbbbb
1 5 00000100 3 30 cccccccccccccccc 0 1 0 0000000000000000
0 6 00000100 3 00 0000000000000000 0 1 0 1122ccccbbbbbbbb
1 7 00000100 3 c0 dddd000000000000 0 1 0 0000000000000000
0 8 00000100 3 00 0000000000000000 0 1 0 ddddccccbbbbbbbb
1 9 00000108 3 ff 0123456789abcdef 0 1 0 0000000000000000
1 a 00000108 3 5a ffeeddccbbaa9988 0 4 0 0000000000000000
0 b 00000108 3 00 0000000000000000 0 1 0 01ee45ccbbab99ef
1 c 00000110 3 81 7700000000000066 0 2 0 0000000000000000
1 d 00000118 3 ff 5555555555555555 1 1 2 0000000000000000
0 e 00000100 3 00 0000000000000000 1 1 2 0000011800000118
1 f 00000120 3 ff 0f0e0d0c0b0a0908 0 1 0 0000000000000000
1 0 00000124 2 f0 4444444400000000 0 1 0 0000000000000000
0 1 00000120 3 00 0000000000000000 0 1 0 444444440b0a0908
0 2 00000124 2 00 0000000000000000 0 1 0 444444440b0a0908
1 3 00000128 3 3c 0000aabbccdd0000 0 4 0 0000000000000000

/* vlog.f */
src/axi_ahb_pkg.sv
src/axi_write_capture.sv
src/cmd_buffer.sv
src/ahb_master.sv
src/axi_ahb_bridge.sv
testbench/ahb_slave_model.sv
testbench/tb_axi_ahb_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator

verilator --binary --timing --assert -f vlog.f --top-module tb_axi_ahb_bridge -o sim_tb
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Done: errors found" sim.log; then
   echo "FAIL"
   exit 1
fi

echo "PASS"
exit 0

/* testbench/tb_axi_ahb_bridge.sv */
`timescale 1ns/1ps

module tb_axi_ahb_bridge;

   localparam int max_vec        = 32;
   localparam int reset_cycles   = 8;
   localparam int cycles_per_vec = 40;

   logic        bus_clk;
   logic        rst;
   logic        axi_awvalid, axi_awready, axi_wvalid, axi_wready, axi_wlast;
   logic [3:0]  axi_awid, axi_arid, axi_bid, axi_rid;
   logic [31:0] axi_awaddr, axi_araddr;
   logic [2:0]  axi_awsize, axi_arsize;
   logic [63:0] axi_wdata, axi_rdata;
   logic [7:0]  axi_wstrb;
   logic        axi_bvalid, axi_bready, axi_arvalid, axi_arready;
   logic        axi_rvalid, axi_rready, axi_rlast;
   logic [1:0]  axi_bresp, axi_rresp;
   logic [31:0] ahb_haddr;
   logic [2:0]  ahb_hsize;
   logic [1:0]  ahb_htrans;
   logic        ahb_hwrite, ahb_hready, ahb_hresp;
   logic [63:0] ahb_hwdata, ahb_hrdata;
   logic        slave_err;
   logic        log_clear;

   // Vector table
   logic        v_op    [max_vec];
   logic [3:0]  v_id    [max_vec];
   logic [31:0] v_addr  [max_vec];
   logic [2:0]  v_size  [max_vec];
   logic [7:0]  v_strb  [max_vec];
   logic [63:0] v_wdata [max_vec];
   logic        v_err   [max_vec];
   logic [3:0]  v_xfers [max_vec];
   logic [1:0]  v_resp  [max_vec];
   logic [63:0] v_rdata [max_vec];
   int          nvec;
   int          errors;
   int          checks;
   int          cycle_count;
   int          cycle_limit;
   logic [31:0] lfsr;

   axi_ahb_bridge i_dut (.*);

   ahb_slave_model i_slave (
      .bus_clk(bus_clk), .rst(rst), .haddr(ahb_haddr), .hsize(ahb_hsize),
      .htrans(ahb_htrans), .hwrite(ahb_hwrite), .hwdata(ahb_hwdata),
      .hrdata(ahb_hrdata), .hready(ahb_hready), .hresp(ahb_hresp),
      .err_en(slave_err), .log_clear(log_clear)
   );

   always #20 bus_clk = ~bus_clk;

   always @(posedge bus_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("Simulation timed out after %0d cycles", cycle_count);
         $display("Done: errors found");
         $finish;
      end
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Size of an aligned strobe block or -1 when the strobes form none
   function automatic int block_size(input logic [7:0] strb);
      case (strb)
         8'hff:                      return 3;
         8'h0f, 8'hf0:               return 2;
         8'h03, 8'h0c, 8'h30, 8'hc0: return 1;
         default:                    return -1;
      endcase
   endfunction

   // Lane of the n-th set strobe counted from lane 0
   function automatic int nth_lane(input logic [7:0] strb, input int n);
      int seen;
      seen = 0;
      for (int b = 0; b < 8; b++) begin
         if (strb[b]) begin
            if (seen == n)
               return b;
            seen++;
         end
      end
      return 0;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("Error: %s is %h, expected %h", name, got, exp);
      end
   endtask

   task automatic load_vectors();
      int    fd;
      string line;
      fd = $fopen("testbench/bridge_stimulus.dat", "r");
      if (fd == 0) begin
         errors++;
         $display("Could not open the stimulus file");
         return;
      end
      while (!$feof(fd) && nvec < max_vec) begin
         if ($fgets(line, fd) == 0)
            break;
         if (line.len() < 2 || line.getc(0) == 8'h23)
            continue;                              // Blank or comment line
         if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h", v_op[nvec], v_id[nvec],
                     v_addr[nvec], v_size[nvec], v_strb[nvec], v_wdata[nvec], v_err[nvec],
                     v_xfers[nvec], v_resp[nvec], v_rdata[nvec]) == 10)
            nvec++;
      end
      $fclose(fd);
   endtask

   task automatic send_write(input int k);
      bit aw_done;
      bit w_done;
      aw_done = 0;
      w_done  = 0;
      @(posedge bus_clk);
      axi_awvalid <= 1'b1;
      axi_awid    <= v_id[k];
      axi_awaddr  <= v_addr[k];
      axi_awsize  <= v_size[k];
      axi_wvalid  <= 1'b1;
      axi_wdata   <= v_wdata[k];
      axi_wstrb   <= v_strb[k];
      axi_wlast   <= 1'b1;
      while (!(aw_done && w_done)) begin
         @(negedge bus_clk);
         if (axi_awvalid && axi_awready)
            aw_done = 1;
         if (axi_wvalid && axi_wready)
            w_done = 1;
         @(posedge bus_clk);
         if (aw_done)
            axi_awvalid <= 1'b0;
         if (w_done)
            axi_wvalid <= 1'b0;
      end
   endtask

   task automatic send_read(input int k);
      bit done;
      done = 0;
      @(posedge bus_clk);
      axi_arvalid <= 1'b1;
      axi_arid    <= v_id[k];
      axi_araddr  <= v_addr[k];
      axi_arsize  <= v_size[k];
      while (!done) begin
         @(negedge bus_clk);
         done = axi_arvalid && axi_arready;
         @(posedge bus_clk);
         if (done)
            axi_arvalid <= 1'b0;
      end
   endtask

   // Random B and R back-pressure until the response is taken
   task automatic take_response(input int k);
      bit done;
      done = 0;
      while (!done) begin
         @(posedge bus_clk);
         lfsr = lfsr_step(lfsr);
         axi_bready <= lfsr[0];
         axi_rready <= lfsr[0];
         @(negedge bus_clk);
         if (v_op[k] && axi_bvalid && axi_bready) begin
            done = 1;
            check_value("axi_bid", 64'(axi_bid), 64'(v_id[k]));
            check_value("axi_bresp", 64'(axi_bresp), 64'(v_resp[k]));
         end else if (!v_op[k] && axi_rvalid && axi_rready) begin
            done = 1;
            check_value("axi_rid", 64'(axi_rid), 64'(v_id[k]));
            check_value("axi_rresp", 64'(axi_rresp), 64'(v_resp[k]));
            check_value("axi_rdata", axi_rdata, v_rdata[k]);
            check_value("axi_rlast", 64'(axi_rlast), 64'd1);
         end
      end
      @(posedge bus_clk);
      axi_bready <= 1'b0;
      axi_rready <= 1'b0;
   endtask

   task automatic check_transfers(input int k);
      logic [31:0] exp_addr;
      logic [2:0]  exp_size;
      int          bs;
      check_value("transfer count", 64'(i_slave.xfer_count), 64'(v_xfers[k]));
      if (i_slave.xfer_count != v_xfers[k] || v_xfers[k] > 4'd8)
         return;
      bs = block_size(v_strb[k]);
      for (int i = 0; i < int'(v_xfers[k]); i++) begin
         exp_addr = v_addr[k];
         exp_size = v_size[k];
         if (v_op[k] && v_size[k] == 3'd3) begin
            exp_addr[2:0] = 3'(nth_lane(v_strb[k], i));
            exp_size      = (bs >= 0) ? 3'(bs) : 3'd0;   // Split goes bytewise
         end
         check_value("ahb_haddr", 64'(i_slave.addr_log[i]), 64'(exp_addr));
         check_value("ahb_hsize", 64'(i_slave.size_log[i]), 64'(exp_size));
         check_value("ahb_hwrite", 64'(i_slave.write_log[i]), 64'(v_op[k]));
      end
   endtask

   // ******************************************************************
   // Main sequence
   // ******************************************************************
   initial begin
      bus_clk     = 1'b0;
      rst         = 1'b1;
      axi_awvalid = 1'b0;
      axi_awid    = '0;
      axi_awaddr  = '0;
      axi_awsize  = '0;
      axi_wvalid  = 1'b0;
      axi_wdata   = '0;
      axi_wstrb   = '0;
      axi_wlast   = 1'b0;
      axi_bready  = 1'b0;
      axi_arvalid = 1'b0;
      axi_arid    = '0;
      axi_araddr  = '0;
      axi_arsize  = '0;
      axi_rready  = 1'b0;
      slave_err   = 1'b0;
      log_clear   = 1'b0;
      nvec        = 0;
      errors      = 0;
      checks      = 0;
      cycle_count = 0;
      lfsr        = 32'he367c406;
      load_vectors();
      cycle_limit = nvec * cycles_per_vec + reset_cycles;
      repeat (reset_cycles) @(posedge bus_clk);
      rst <= 1'b0;
      for (int k = 0; k < nvec; k++) begin
         @(posedge bus_clk);
         log_clear <= 1'b1;
         slave_err <= v_err[k];
         @(posedge bus_clk);
         log_clear <= 1'b0;
         if (v_op[k])
            send_write(k);
         else
            send_read(k);
         take_response(k);
         check_transfers(k);
      end
      $display("Vectors: %0d, checks: %0d, errors: %0d", nvec, checks, errors);
      if (errors == 0 && nvec > 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

/* testbench/ahb_slave_model.sv */
`timescale 1ns/1ps

module ahb_slave_model (
   input  logic        bus_clk,
   input  logic        rst,
   input  logic [31:0] haddr,
   input  logic [2:0]  hsize,
   input  logic [1:0]  htrans,
   input  logic        hwrite,
   input  logic [63:0] hwdata,
   output logic [63:0] hrdata,
   output logic        hready,
   output logic        hresp,
   input  logic        err_en,      // Answer the next transfers with an error
   input  logic        log_clear
);

   logic [31:0] lfsr_q;
   logic [31:0] lfsr_a;
   logic [31:0] lfsr_b;
   logic        dp;                 // Data phase in progress
   logic [31:0] dp_addr;
   logic [2:0]  dp_size;
   logic        dp_write;
   logic        dp_err;
   logic [1:0]  wait_cnt;
   logic [7:0]  lanes;
   logic        start;
   logic [63:0] mem [0:255];
   logic [3:0]  xfer_count;
   logic [31:0] addr_log [0:7];
   logic [2:0]  size_log [0:7];
   logic        write_log [0:7];

   function automatic logic [31:0] advance_lfsr(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1
   endfunction

   function automatic logic [7:0] lane_mask(input logic [2:0] off, input logic [2:0] size);
      logic [8:0] m;
      m = (9'd1 << (4'd1 << size)) - 9'd1;
      return 8'(m << off);
   endfunction

   assign start  = (htrans == 2'b10) & hready & ~dp;
   assign lfsr_a = advance_lfsr(lfsr_q);
   assign lfsr_b = advance_lfsr(lfsr_a);
   assign hrdata = mem[dp_addr[10:3]];
   assign lanes  = lane_mask(dp_addr[2:0], dp_size);

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         dp         <= 1'b0;
         hready     <= 1'b1;
         hresp      <= 1'b0;
         lfsr_q     <= 32'he367c406;
         xfer_count <= 4'd0;
         for (int i = 0; i < 256; i++)
            mem[i] <= {32'hf1110000 ^ (32'(i) << 3), ~(32'(i) << 3)};
      end else begin
         if (log_clear)
            xfer_count <= 4'd0;
         if (start) begin
            dp       <= 1'b1;
            dp_addr  <= haddr;
            dp_size  <= hsize;
            dp_write <= hwrite;
            dp_err   <= err_en;
            wait_cnt <= {lfsr_a[0], lfsr_b[0]};   // 0 to 3 wait states
            lfsr_q   <= lfsr_b;
            if (xfer_count < 4'd8) begin
               addr_log[xfer_count[2:0]]  <= haddr;
               size_log[xfer_count[2:0]]  <= hsize;
               write_log[xfer_count[2:0]] <= hwrite;
            end
            xfer_count <= xfer_count + 4'd1;
            if ({lfsr_a[0], lfsr_b[0]} != 2'd0) begin
               hready <= 1'b0;
            end else if (err_en) begin
               hready <= 1'b0;
               hresp  <= 1'b1;
            end
         end else if (dp && hready) begin
            dp    <= 1'b0;                         // Transfer completes here
            hresp <= 1'b0;
            if (dp_write && !hresp) begin
               for (int b = 0; b < 8; b++) begin
                  if (lanes[b])
                     mem[dp_addr[10:3]][b*8 +: 8] <= hwdata[b*8 +: 8];
               end
            end
         end else if (dp) begin
            if (wait_cnt > 2'd1) begin
               wait_cnt <= wait_cnt - 2'd1;
            end else if (wait_cnt == 2'd1) begin
               wait_cnt <= 2'd0;
               if (dp_err)
                  hresp <= 1'b1;                   // First error cycle
               else
                  hready <= 1'b1;
            end else begin
               hready <= 1'b1;                     // Second error cycle
            end
         end
      end
   end

endmodule

/* src/axi_ahb_bridge.sv */
`timescale 1ns/1ps

module axi_ahb_bridge (
   input  logic                                bus_clk,
   input  logic                                rst,
   // AXI write address
   input  logic                                axi_awvalid,
   output logic                                axi_awready,
   input  logic [axi_ahb_pkg::id_width-1:0]    axi_awid,
   input  logic [axi_ahb_pkg::addr_width-1:0]  axi_awaddr,
   input  logic [2:0]                          axi_awsize,
   // AXI write data
   input  logic                                axi_wvalid,
   output logic                                axi_wready,
   input  logic [axi_ahb_pkg::data_width-1:0]  axi_wdata,
   input  logic [axi_ahb_pkg::strb_width-1:0]  axi_wstrb,
   input  logic                                axi_wlast,
   // AXI write response
   output logic                                axi_bvalid,
   input  logic                                axi_bready,
   output logic [axi_ahb_pkg::id_width-1:0]    axi_bid,
   output logic [1:0]                          axi_bresp,
   // AXI read address
   input  logic                                axi_arvalid,
   output logic                                axi_arready,
   input  logic [axi_ahb_pkg::id_width-1:0]    axi_arid,
   input  logic [axi_ahb_pkg::addr_width-1:0]  axi_araddr,
   input  logic [2:0]                          axi_arsize,
   // AXI read data
   output logic                                axi_rvalid,
   input  logic                                axi_rready,
   output logic [axi_ahb_pkg::id_width-1:0]    axi_rid,
   output logic [axi_ahb_pkg::data_width-1:0]  axi_rdata,
   output logic [1:0]                          axi_rresp,
   output logic                                axi_rlast,
   // AHB-Lite master
   output logic [axi_ahb_pkg::addr_width-1:0]  ahb_haddr,
   output logic [2:0]                          ahb_hsize,
   output logic [1:0]                          ahb_htrans,
   output logic                                ahb_hwrite,
   output logic [axi_ahb_pkg::data_width-1:0]  ahb_hwdata,
   input  logic [axi_ahb_pkg::data_width-1:0]  ahb_hrdata,
   input  logic                                ahb_hready,
   input  logic                                ahb_hresp
);

   // Capture to buffer
   logic                                cmd_valid;
   logic                                cmd_ready;
   logic                                cmd_write;
   logic [axi_ahb_pkg::id_width-1:0]    cmd_id;
   logic [axi_ahb_pkg::addr_width-1:0]  cmd_addr;
   logic [2:0]                          cmd_size;
   logic [axi_ahb_pkg::strb_width-1:0]  cmd_strb;
   logic [axi_ahb_pkg::data_width-1:0]  cmd_wdata;

   // Buffer to AHB master
   logic                                buf_valid;
   logic                                buf_write;
   logic [axi_ahb_pkg::id_width-1:0]    buf_id;
   logic [axi_ahb_pkg::addr_width-1:0]  buf_addr;
   logic [2:0]                          buf_size;
   logic                                buf_aligned;
   logic [axi_ahb_pkg::strb_width-1:0]  buf_strb;
   logic [axi_ahb_pkg::data_width-1:0]  buf_wdata;
   logic                                buf_release;

   axi_write_capture i_capture (.*);

   cmd_buffer i_cmd_buffer (.*);

   ahb_master i_ahb_master (.*);

endmodule

/* src/ahb_master.sv */
`timescale 1ns/1ps

module ahb_master (
   input  logic                                bus_clk,
   input  logic                                rst,
   // Buffer entry
   input  logic                                buf_valid,
   input  logic                                buf_write,
   input  logic [axi_ahb_pkg::id_width-1:0]    buf_id,
   input  logic [axi_ahb_pkg::addr_width-1:0]  buf_addr,
   input  logic [2:0]                          buf_size,
   input  logic                                buf_aligned,
   input  logic [axi_ahb_pkg::strb_width-1:0]  buf_strb,
   input  logic [axi_ahb_pkg::data_width-1:0]  buf_wdata,
   output logic                                buf_release,
   // AHB-Lite
   output logic [axi_ahb_pkg::addr_width-1:0]  ahb_haddr,
   output logic [2:0]                          ahb_hsize,
   output logic [1:0]                          ahb_htrans,
   output logic                                ahb_hwrite,
   output logic [axi_ahb_pkg::data_width-1:0]  ahb_hwdata,
   input  logic [axi_ahb_pkg::data_width-1:0]  ahb_hrdata,
   input  logic                                ahb_hready,
   input  logic                                ahb_hresp,
   // Write response
   output logic                                axi_bvalid,
   input  logic                                axi_bready,
   output logic [axi_ahb_pkg::id_width-1:0]    axi_bid,
   output logic [1:0]                          axi_bresp,
   // Read response
   output logic                                axi_rvalid,
   input  logic                                axi_rready,
   output logic [axi_ahb_pkg::id_width-1:0]    axi_rid,
   output logic [axi_ahb_pkg::data_width-1:0]  axi_rdata,
   output logic [1:0]                          axi_rresp,
   output logic                                axi_rlast
);

   axi_ahb_pkg::ahb_state_u             state_q;
   axi_ahb_pkg::ahb_state_u             state_d;
   logic [2:0]                          ptr_q;       // Current byte lane
   logic [2:0]                          ptr_d;
   logic [3:0]                          first_hit;   // {found, lane}
   logic [3:0]                          next_hit;
   logic                                more_bytes;
   logic                                data_end;
   logic                                resp_fire;
   logic                                err_q;
   logic [axi_ahb_pkg::data_width-1:0]  rdata_q;
   logic [axi_ahb_pkg::addr_width-1:0]  last_addr_q; // Last accepted write address

   // Lowest set strobe at or above start
   function automatic logic [3:0] find_strb(input logic [axi_ahb_pkg::strb_width-1:0] strb,
                                            input logic [3:0] start);
      logic [3:0] res;
      res = 4'd0;
      for (int j = axi_ahb_pkg::strb_width - 1; j >= 0; j--) begin
         if (strb[j] && (4'(j) >= start))
            res = {1'b1, 3'(j)};
      end
      return res;
   endfunction

   assign first_hit  = find_strb(buf_strb, 4'd0);
   assign next_hit   = find_strb(buf_strb, {1'b0, ptr_q} + 4'd1);
   assign more_bytes = state_q.f.write & ~buf_aligned & next_hit[3] & ~ahb_hresp;
   assign data_end   = (state_q.f.phase == axi_ahb_pkg::PHASE_DATA) & ahb_hready;
   assign resp_fire  = (axi_bvalid & axi_bready) | (axi_rvalid & axi_rready);

   // ******************************************************************
   // Transfer FSM
   // ******************************************************************
   always_comb begin
      state_d     = state_q;
      ptr_d       = ptr_q;
      buf_release = 1'b0;
      case (state_q.f.phase)
         axi_ahb_pkg::PHASE_IDLE: begin
            if (buf_valid) begin
               state_d.name = buf_write ? axi_ahb_pkg::CMD_WR : axi_ahb_pkg::CMD_RD;
               ptr_d = (buf_write & ~buf_aligned) ? first_hit[2:0] : buf_addr[2:0];
            end
         end
         axi_ahb_pkg::PHASE_CMD:
            state_d.f.phase = axi_ahb_pkg::PHASE_DATA;   // Single address cycle
         axi_ahb_pkg::PHASE_DATA: begin
            if (ahb_hready) begin
               if (more_bytes) begin
                  state_d.f.phase = axi_ahb_pkg::PHASE_CMD;   // Next byte of the split
                  ptr_d = next_hit[2:0];
               end else begin
                  state_d.f.phase = axi_ahb_pkg::PHASE_DONE;
               end
            end
         end
         axi_ahb_pkg::PHASE_DONE: begin
            if (resp_fire) begin
               state_d.name = axi_ahb_pkg::IDLE;
               buf_release  = 1'b1;
            end
         end
      endcase
   end

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         state_q.name <= axi_ahb_pkg::IDLE;
         err_q        <= 1'b0;
      end else begin
         state_q <= state_d;
         if ((state_q.f.phase == axi_ahb_pkg::PHASE_IDLE) && buf_valid)
            err_q <= 1'b0;
         else if (data_end && ahb_hresp)
            err_q <= 1'b1;
      end
   end

   always_ff @(posedge bus_clk) begin
      ptr_q <= ptr_d;
      if (data_end && !state_q.f.write)
         rdata_q <= ahb_hrdata;
      if ((ahb_htrans == axi_ahb_pkg::htrans_nonseq) && ahb_hready && ahb_hwrite)
         last_addr_q <= ahb_haddr;
   end

   // AHB drive, address phase only while in CMD
   assign ahb_haddr  = {buf_addr[axi_ahb_pkg::addr_width-1:3], ptr_q};
   assign ahb_hsize  = buf_aligned ? buf_size : 3'd0;    // Split writes go bytewise
   assign ahb_htrans = (state_q.f.phase == axi_ahb_pkg::PHASE_CMD) ?
                       axi_ahb_pkg::htrans_nonseq : axi_ahb_pkg::htrans_idle;
   assign ahb_hwrite = state_q.f.write;
   assign ahb_hwdata = buf_wdata;

   // Responses held in DONE
   assign axi_bvalid = (state_q.f.phase == axi_ahb_pkg::PHASE_DONE) & state_q.f.write;
   assign axi_bid    = buf_id;
   assign axi_bresp  = err_q ? axi_ahb_pkg::resp_slverr : axi_ahb_pkg::resp_okay;
   assign axi_rvalid = (state_q.f.phase == axi_ahb_pkg::PHASE_DONE) & ~state_q.f.write;
   assign axi_rid    = buf_id;
   assign axi_rdata  = err_q ? {2{last_addr_q}} : rdata_q;
   assign axi_rresp  = err_q ? axi_ahb_pkg::resp_slverr : axi_ahb_pkg::resp_okay;
   assign axi_rlast  = 1'b1;

   a_addr_aligned: assert property (@(posedge bus_clk) disable iff (rst)
      (ahb_htrans == axi_ahb_pkg::htrans_nonseq) |->
         ((ahb_haddr[2:0] & ~(3'h7 << ahb_hsize)) == 3'h0))
      else $error("Misaligned AHB transfer haddr=%h hsize=%0d", ahb_haddr, ahb_hsize);

   a_two_cycle_err: assert property (@(posedge bus_clk) disable iff (rst)
      (ahb_hready & ahb_hresp) |-> $past(~ahb_hready & ahb_hresp))
      else $error("AHB error completed without a first error cycle");

endmodule

/* src/cmd_buffer.sv */
`timescale 1ns/1ps

module cmd_buffer (
   input  logic                                bus_clk,
   input  logic                                rst,
   // Command in
   input  logic                                cmd_valid,
   output logic                                cmd_ready,
   input  logic                                cmd_write,
   input  logic [axi_ahb_pkg::id_width-1:0]    cmd_id,
   input  logic [axi_ahb_pkg::addr_width-1:0]  cmd_addr,
   input  logic [2:0]                          cmd_size,
   input  logic [axi_ahb_pkg::strb_width-1:0]  cmd_strb,
   input  logic [axi_ahb_pkg::data_width-1:0]  cmd_wdata,
   // Entry out to the AHB master
   output logic                                buf_valid,
   output logic                                buf_write,
   output logic [axi_ahb_pkg::id_width-1:0]    buf_id,
   output logic [axi_ahb_pkg::addr_width-1:0]  buf_addr,
   output logic [2:0]                          buf_size,
   output logic                                buf_aligned,
   output logic [axi_ahb_pkg::strb_width-1:0]  buf_strb,
   output logic [axi_ahb_pkg::data_width-1:0]  buf_wdata,
   input  logic                                buf_release
);

   logic        full;
   logic        load;
   logic        blk_hit;       // Strobes form one naturally aligned block
   logic [2:0]  blk_size;
   logic [2:0]  blk_off;       // Lowest set strobe
   logic        dw_write;
   logic        aligned_in;
   logic        rewrite;

   assign cmd_ready = ~full;
   assign load      = cmd_valid & cmd_ready;
   assign buf_valid = full;

   // ******************************************************************
   // Strobe pattern decode
   // ******************************************************************
   always_comb begin
      blk_hit  = 1'b1;
      blk_size = 3'd0;
      blk_off  = 3'd0;
      case (cmd_strb)
         8'hff:                      blk_size = 3'd3;
         8'h0f, 8'hf0:               blk_size = 3'd2;
         8'h03, 8'h0c, 8'h30, 8'hc0: blk_size = 3'd1;
         default:                    blk_hit  = 1'b0;
      endcase
      for (int j = axi_ahb_pkg::strb_width - 1; j >= 0; j--) begin
         if (cmd_strb[j])
            blk_off = 3'(j);
      end
   end

   // Reads and sub-doubleword writes go out as given
   assign dw_write   = cmd_write & (cmd_size == 3'd3);
   assign aligned_in = ~dw_write | blk_hit;
   assign rewrite    = dw_write & blk_hit;

   always_ff @(posedge bus_clk) begin
      if (rst)
         full <= 1'b0;
      else if (load)
         full <= 1'b1;
      else if (buf_release)
         full <= 1'b0;
   end

   always_ff @(posedge bus_clk) begin
      if (load) begin
         buf_write   <= cmd_write;
         buf_id      <= cmd_id;
         buf_addr    <= {cmd_addr[axi_ahb_pkg::addr_width-1:3],
                         rewrite ? blk_off : cmd_addr[2:0]};
         buf_size    <= rewrite ? blk_size : cmd_size;
         buf_aligned <= aligned_in;
         buf_strb    <= cmd_strb;
         buf_wdata   <= cmd_wdata;
      end
   end

   a_release_full: assert property (@(posedge bus_clk) disable iff (rst)
      buf_release |-> buf_valid)
      else $error("Buffer released while empty");

endmodule

/* src/axi_write_capture.sv */
`timescale 1ns/1ps

module axi_write_capture (
   input  logic                                bus_clk,
   input  logic                                rst,
   // Write address
   input  logic                                axi_awvalid,
   output logic                                axi_awready,
   input  logic [axi_ahb_pkg::id_width-1:0]    axi_awid,
   input  logic [axi_ahb_pkg::addr_width-1:0]  axi_awaddr,
   input  logic [2:0]                          axi_awsize,
   // Write data
   input  logic                                axi_wvalid,
   output logic                                axi_wready,
   input  logic [axi_ahb_pkg::data_width-1:0]  axi_wdata,
   input  logic [axi_ahb_pkg::strb_width-1:0]  axi_wstrb,
   input  logic                                axi_wlast,
   // Read address
   input  logic                                axi_arvalid,
   output logic                                axi_arready,
   input  logic [axi_ahb_pkg::id_width-1:0]    axi_arid,
   input  logic [axi_ahb_pkg::addr_width-1:0]  axi_araddr,
   input  logic [2:0]                          axi_arsize,
   // Command to the buffer
   output logic                                cmd_valid,
   input  logic                                cmd_ready,
   output logic                                cmd_write,
   output logic [axi_ahb_pkg::id_width-1:0]    cmd_id,
   output logic [axi_ahb_pkg::addr_width-1:0]  cmd_addr,
   output logic [2:0]                          cmd_size,
   output logic [axi_ahb_pkg::strb_width-1:0]  cmd_strb,
   output logic [axi_ahb_pkg::data_width-1:0]  cmd_wdata
);

   logic                                ports_en;   // Opens the readies after reset
   logic                                aw_held;
   logic                                w_held;
   logic [axi_ahb_pkg::id_width-1:0]    aw_id;
   logic [axi_ahb_pkg::addr_width-1:0]  aw_addr;
   logic [2:0]                          aw_size;
   logic [axi_ahb_pkg::data_width-1:0]  w_data;
   logic [axi_ahb_pkg::strb_width-1:0]  w_strb;
   logic                                wr_sel;
   logic                                aw_fire;
   logic                                w_fire;
   logic                                wr_sent;

   assign wr_sel  = aw_held & w_held;           // Both halves present
   assign aw_fire = axi_awvalid & axi_awready;
   assign w_fire  = axi_wvalid & axi_wready;
   assign wr_sent = cmd_valid & cmd_ready & wr_sel;

   assign axi_awready = ports_en & ~aw_held;
   assign axi_wready  = ports_en & ~w_held;
   assign axi_arready = ports_en & ~wr_sel & cmd_ready;   // Writes win

   // Selected command, pending read passes straight through
   assign cmd_valid = wr_sel | (ports_en & axi_arvalid);
   assign cmd_write = wr_sel;
   assign cmd_id    = wr_sel ? aw_id   : axi_arid;
   assign cmd_addr  = wr_sel ? aw_addr : axi_araddr;
   assign cmd_size  = wr_sel ? aw_size : axi_arsize;
   assign cmd_strb  = w_strb;
   assign cmd_wdata = w_data;

   always_ff @(posedge bus_clk) begin
      if (rst) begin
         ports_en <= 1'b0;
         aw_held  <= 1'b0;
         w_held   <= 1'b0;
      end else begin
         ports_en <= 1'b1;
         if (aw_fire)
            aw_held <= 1'b1;
         else if (wr_sent)
            aw_held <= 1'b0;
         if (w_fire)
            w_held <= 1'b1;
         else if (wr_sent)
            w_held <= 1'b0;
      end
   end

   always_ff @(posedge bus_clk) begin
      if (aw_fire) begin
         aw_id   <= axi_awid;
         aw_addr <= axi_awaddr;
         aw_size <= axi_awsize;
      end
      if (w_fire) begin
         w_data <= axi_wdata;
         w_strb <= axi_wstrb;
      end
   end

   a_single_beat: assert property (@(posedge bus_clk) disable iff (rst) w_fire |-> axi_wlast)
      else $error("Write beat accepted without wlast");

endmodule

/* src/axi_ahb_pkg.sv */
package axi_ahb_pkg;

   // ******************************************************************
   // Bus widths
   // ******************************************************************
   localparam int unsigned addr_width = 32;
   localparam int unsigned data_width = 64;
   localparam int unsigned strb_width = 8;   // One strobe per byte lane
   localparam int unsigned id_width   = 4;

   // AXI response codes
   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   // AHB transfer types, only two are ever issued
   localparam logic [1:0] htrans_idle   = 2'b00;
   localparam logic [1:0] htrans_nonseq = 2'b10;

   typedef enum logic [1:0] {
      PHASE_IDLE = 2'd0,
      PHASE_CMD  = 2'd1,   // Address phase on AHB
      PHASE_DATA = 2'd2,   // Waiting for hready
      PHASE_DONE = 2'd3    // Response held on B or R
   } ahb_phase_t;

   // ******************************************************************
   // Controller state, top bit is the direction
   // ******************************************************************
   typedef enum logic [2:0] {
      IDLE    = 3'b000,
      CMD_RD  = 3'b001,
      DATA_RD = 3'b010,
      DONE_RD = 3'b011,
      CMD_WR  = 3'b101,
      DATA_WR = 3'b110,
      DONE_WR = 3'b111
   } ahb_state_e;

   typedef struct packed {
      logic       write;
      ahb_phase_t phase;
   } ahb_state_fields_t;

   typedef union packed {
      ahb_state_e        name;
      ahb_state_fields_t f;
   } ahb_state_u;

endpackage
